// File: rtl/exec_defines.svh
/* Widths, special register numbers, multiply latency and counter offsets
   for the execute stage. Included by any file that needs them */
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Datapath
`define EXEC_DATA_WIDTH 32
`define EXEC_REG_BITS 5

// Reads of this register return the PC, writes to it are branches
`define EXEC_REG_PC 31

// Depth of the multiply pipeline before the merge register
`define EXEC_MUL_STAGES 3

// Branch event counters, APB word offsets
`define EXEC_CNT_MISPREDICT 'h0
`define EXEC_CNT_COND_TAKEN 'h4
`define EXEC_CNT_COND_NOT_TAKEN 'h8
`define EXEC_CNT_UNCOND 'hC

`endif

// File: rtl/exec_pkg.sv
/* Types shared by the execute stage units, imported in module headers */
`include "exec_defines.svh"

package exec_pkg;

	typedef logic [`EXEC_DATA_WIDTH-1:0] data_t;
	typedef logic [`EXEC_REG_BITS-1:0] reg_idx_t;

	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_OR  = 4'd3,
		OP_XOR = 4'd4,
		OP_SHL = 4'd5,
		OP_SHR = 4'd6,
		OP_SLT = 4'd7,
		OP_EQ  = 4'd8,
		OP_MUL = 4'd9
	} alu_op_t;

	typedef enum logic [2:0] {
		BR_NONE     = 3'd0,
		BR_ZERO     = 3'd1,
		BR_NOT_ZERO = 3'd2,
		BR_ALWAYS   = 3'd3,
		BR_CALL     = 3'd4
	} branch_type_t;

	// Travels alongside the product through the multiply pipeline
	typedef struct packed {
		reg_idx_t dest_reg;
		logic     write;
		data_t    pc;
	} mul_meta_t;

endpackage

// File: rtl/exec_ifs.sv
/* Interfaces between execute stage units: the registered result and the
   branch event pulses */

interface exec_result_if import exec_pkg::*; ();
	logic     valid;
	reg_idx_t dest_reg;
	logic     write;
	data_t    value;
	data_t    pc;

	modport producer (output valid, dest_reg, write, value, pc);
	modport consumer (input valid, dest_reg, write, value, pc);
endinterface

interface branch_event_if ();
	logic mispredict;
	logic cond_taken;
	logic cond_not_taken;
	logic uncond_taken;

	modport source (output mispredict, cond_taken, cond_not_taken, uncond_taken);
	modport sink (input mispredict, cond_taken, cond_not_taken, uncond_taken);
endinterface

// File: rtl/operand_bypass.sv
/* Source operand bypass. One instance per source register, picks the newest
   value among the PC, in-flight results and the register file */
`include "exec_defines.svh"

module operand_bypass import exec_pkg::*; (
	input  reg_idx_t sel_i,
	input  data_t    pc_i,
	input  data_t    rf_value_i,
	exec_result_if.consumer ex,
	input  reg_idx_t ma_reg_i,
	input  logic     ma_write_i,
	input  data_t    ma_value_i,
	input  reg_idx_t wb_reg_i,
	input  logic     wb_write_i,
	input  data_t    wb_value_i,
	output data_t    value_o
);

	always_comb
	begin
		if (sel_i == reg_idx_t'(`EXEC_REG_PC))
			value_o = pc_i;
		// Youngest result first
		else if (ex.write && ex.dest_reg == sel_i)
			value_o = ex.value;
		else if (ma_write_i && ma_reg_i == sel_i)
			value_o = ma_value_i;
		else if (wb_write_i && wb_reg_i == sel_i)
			value_o = wb_value_i;
		else
			value_o = rf_value_i;
	end

endmodule

// File: rtl/branch_resolve.sv
/* Branch resolution for the instruction in decode. Raises rollback on a
   misprediction and emits one pulse per branch event */
`include "exec_defines.svh"

module branch_resolve import exec_pkg::*; (
	input  logic         valid_i,
	input  branch_type_t branch_type_i,
	input  logic         predicted_i,
	input  data_t        pc_i,
	input  data_t        offset_i,
	input  data_t        operand1_i,
	input  data_t        alu_result_i,
	input  reg_idx_t     dest_reg_i,
	input  logic         write_i,
	output logic         rollback_request_o,
	output data_t        rollback_pc_o,
	branch_event_if.source events
);

	logic  taken;
	logic  is_cond;
	data_t target;

	always_comb
	begin
		taken = 1'b0;
		target = pc_i + offset_i;
		if (write_i && dest_reg_i == reg_idx_t'(`EXEC_REG_PC))
		begin
			// ALU op with PC destination acts as an indirect jump
			taken = 1'b1;
			target = alu_result_i;
		end
		else
		begin
			case (branch_type_i)
				BR_ZERO:     taken = operand1_i == '0;
				BR_NOT_ZERO: taken = operand1_i != '0;
				BR_ALWAYS,
				BR_CALL:     taken = 1'b1;
				default:     taken = 1'b0;
			endcase
		end
	end

	assign is_cond = branch_type_i == BR_ZERO || branch_type_i == BR_NOT_ZERO;

	assign rollback_request_o = valid_i && (predicted_i != taken);
	assign rollback_pc_o = taken ? target : pc_i;

	assign events.mispredict = rollback_request_o;
	assign events.cond_taken = valid_i && is_cond && taken;
	assign events.cond_not_taken = valid_i && is_cond && !taken;
	assign events.uncond_taken = valid_i && !is_cond && taken;

endmodule

// File: rtl/latency_pipe.sv
/* Fixed-depth delay line for any payload type; the valid bits clear on
   reset and the payload just shifts along */
`include "exec_defines.svh"

module latency_pipe #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     valid_i,
	input  payload_t data_i,
	output logic     valid_o,
	output payload_t data_o
);

	localparam int STAGES = `EXEC_MUL_STAGES;

	logic [STAGES-1:0] valid_q;
	payload_t          data_q [STAGES];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			valid_q <= '0;
		else
			valid_q <= {valid_q[STAGES-2:0], valid_i};
	end

	always_ff @(posedge clk)
	begin
		data_q[0] <= data_i;
		for (int i = 1; i < STAGES; i++)
			data_q[i] <= data_q[i-1];
	end

	assign valid_o = valid_q[STAGES-1];
	assign data_o = data_q[STAGES-1];

endmodule

// File: rtl/exec_alu.sv
/* Single-cycle ALU, multiply pipeline and the merge register where the
   two paths meet. Issue collisions at the merge are left to the issuer */
`include "exec_defines.svh"

module exec_alu import exec_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     valid_i,
	input  alu_op_t  op_i,
	input  logic     is_call_i,
	input  data_t    operand1_i,
	input  data_t    operand2_i,
	input  reg_idx_t dest_reg_i,
	input  logic     write_i,
	input  data_t    pc_i,
	output data_t    alu_result_o,
	exec_result_if.producer result
);

	localparam int SHAMT_BITS = $clog2(`EXEC_DATA_WIDTH);

	logic      mul_issue;
	logic      single_issue;
	data_t     product;
	mul_meta_t meta_in;
	logic      prod_valid;
	logic      meta_valid;
	data_t     prod_out;
	mul_meta_t meta_out;
	logic      mul_done;

	always_comb
	begin
		case (op_i)
			OP_ADD:  alu_result_o = operand1_i + operand2_i;
			OP_SUB:  alu_result_o = operand1_i - operand2_i;
			OP_AND:  alu_result_o = operand1_i & operand2_i;
			OP_OR:   alu_result_o = operand1_i | operand2_i;
			OP_XOR:  alu_result_o = operand1_i ^ operand2_i;
			OP_SHL:  alu_result_o = operand1_i << operand2_i[SHAMT_BITS-1:0];
			OP_SHR:  alu_result_o = operand1_i >> operand2_i[SHAMT_BITS-1:0];
			OP_SLT:  alu_result_o = data_t'($signed(operand1_i) < $signed(operand2_i));
			OP_EQ:   alu_result_o = data_t'(operand1_i == operand2_i);
			default: alu_result_o = '0;
		endcase
		// Calls write the return address
		if (is_call_i)
			alu_result_o = pc_i;
	end

	assign mul_issue = valid_i && op_i == OP_MUL;
	assign single_issue = valid_i && op_i != OP_MUL;
	assign product = operand1_i * operand2_i;

	assign meta_in.dest_reg = dest_reg_i;
	assign meta_in.write = write_i;
	assign meta_in.pc = pc_i;

	latency_pipe #(.payload_t(data_t)) u_mul_data (
		.clk     (clk),
		.reset   (reset),
		.valid_i (mul_issue),
		.data_i  (product),
		.valid_o (prod_valid),
		.data_o  (prod_out)
	);

	latency_pipe #(.payload_t(mul_meta_t)) u_mul_meta (
		.clk     (clk),
		.reset   (reset),
		.valid_i (mul_issue),
		.data_i  (meta_in),
		.valid_o (meta_valid),
		.data_o  (meta_out)
	);

	assign mul_done = prod_valid && meta_valid;

	// Merge point, the multiply wins
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			result.valid <= 1'b0;
			result.write <= 1'b0;
		end
		else
		begin
			result.valid <= mul_done || single_issue;
			if (mul_done)
				result.write <= meta_out.write;
			else
				result.write <= single_issue && write_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (mul_done)
		begin
			result.dest_reg <= meta_out.dest_reg;
			result.value <= prod_out;
			result.pc <= meta_out.pc;
		end
		else
		begin
			result.dest_reg <= dest_reg_i;
			result.value <= alu_result_o;
			result.pc <= pc_i;
		end
	end

endmodule

// File: rtl/branch_event_regs.sv
/* APB slave with four branch event counters. Reads return a counter,
   any write clears it. No wait states */
`include "exec_defines.svh"

module branch_event_regs import exec_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	branch_event_if.sink events,
	input  data_t paddr_i,
	input  data_t pwdata_i,
	input  logic  psel_i,
	input  logic  penable_i,
	input  logic  pwrite_i,
	output data_t prdata_o,
	output logic  pready_o
);

	data_t      cnt_q [4];
	logic [3:0] evt;
	logic [1:0] sel;
	logic       addr_hit;
	logic       apb_write;

	assign evt = {events.uncond_taken, events.cond_not_taken,
		events.cond_taken, events.mispredict};

	always_comb
	begin
		addr_hit = 1'b1;
		case (paddr_i)
			`EXEC_CNT_MISPREDICT:     sel = 2'd0;
			`EXEC_CNT_COND_TAKEN:     sel = 2'd1;
			`EXEC_CNT_COND_NOT_TAKEN: sel = 2'd2;
			`EXEC_CNT_UNCOND:         sel = 2'd3;
			default:
			begin
				addr_hit = 1'b0;
				sel = 2'd0;
			end
		endcase
	end

	// Any write access clears the addressed counter
	assign apb_write = psel_i && penable_i && pwrite_i && addr_hit;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 4; i++)
				cnt_q[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (apb_write && sel == 2'(i))
					cnt_q[i] <= '0;
				else if (evt[i])
					cnt_q[i] <= cnt_q[i] + 1'b1;
			end
		end
	end

	assign prdata_o = addr_hit ? cnt_q[sel] : '0;
	assign pready_o = 1'b1;

endmodule

// File: rtl/execute_unit.sv
/* Scalar execute stage top level. Bypasses operands, runs the ALU and the
   multiply, resolves branches and exposes branch counters over APB */

module execute_unit import exec_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         ds_valid_i,
	input  alu_op_t      ds_op_i,
	input  reg_idx_t     ds_src1_i,
	input  reg_idx_t     ds_src2_i,
	input  logic         ds_op2_imm_i,
	input  data_t        ds_immediate_i,
	input  reg_idx_t     ds_dest_i,
	input  logic         ds_write_i,
	input  data_t        ds_pc_i,
	input  branch_type_t ds_branch_type_i,
	input  logic         ds_predicted_i,
	input  data_t        ds_offset_i,
	input  data_t        rf_value1_i,
	input  data_t        rf_value2_i,
	input  reg_idx_t     ma_reg_i,
	input  logic         ma_write_i,
	input  data_t        ma_value_i,
	input  reg_idx_t     wb_reg_i,
	input  logic         wb_write_i,
	input  data_t        wb_value_i,
	output logic         ex_valid_o,
	output reg_idx_t     ex_dest_o,
	output logic         ex_write_o,
	output data_t        ex_result_o,
	output data_t        ex_pc_o,
	output logic         rollback_request_o,
	output data_t        rollback_pc_o,
	input  data_t        paddr_i,
	input  data_t        pwdata_i,
	input  logic         psel_i,
	input  logic         penable_i,
	input  logic         pwrite_i,
	output data_t        prdata_o,
	output logic         pready_o
);

	data_t src1_value;
	data_t src2_value;
	data_t operand2;
	data_t alu_result;
	logic  pc_write;

	exec_result_if ex_res ();
	branch_event_if br_evt ();

	operand_bypass u_bypass1 (
		.sel_i      (ds_src1_i),
		.pc_i       (ds_pc_i),
		.rf_value_i (rf_value1_i),
		.ex         (ex_res.consumer),
		.ma_reg_i   (ma_reg_i),
		.ma_write_i (ma_write_i),
		.ma_value_i (ma_value_i),
		.wb_reg_i   (wb_reg_i),
		.wb_write_i (wb_write_i),
		.wb_value_i (wb_value_i),
		.value_o    (src1_value)
	);

	operand_bypass u_bypass2 (
		.sel_i      (ds_src2_i),
		.pc_i       (ds_pc_i),
		.rf_value_i (rf_value2_i),
		.ex         (ex_res.consumer),
		.ma_reg_i   (ma_reg_i),
		.ma_write_i (ma_write_i),
		.ma_value_i (ma_value_i),
		.wb_reg_i   (wb_reg_i),
		.wb_write_i (wb_write_i),
		.wb_value_i (wb_value_i),
		.value_o    (src2_value)
	);

	assign operand2 = ds_op2_imm_i ? ds_immediate_i : src2_value;

	// A multiply result is not ready here, so it never counts as a jump
	assign pc_write = ds_write_i && ds_op_i != OP_MUL;

	exec_alu u_alu (
		.clk          (clk),
		.reset        (reset),
		.valid_i      (ds_valid_i),
		.op_i         (ds_op_i),
		.is_call_i    (ds_branch_type_i == BR_CALL),
		.operand1_i   (src1_value),
		.operand2_i   (operand2),
		.dest_reg_i   (ds_dest_i),
		.write_i      (ds_write_i),
		.pc_i         (ds_pc_i),
		.alu_result_o (alu_result),
		.result       (ex_res.producer)
	);

	branch_resolve u_branch (
		.valid_i            (ds_valid_i),
		.branch_type_i      (ds_branch_type_i),
		.predicted_i        (ds_predicted_i),
		.pc_i               (ds_pc_i),
		.offset_i           (ds_offset_i),
		.operand1_i         (src1_value),
		.alu_result_i       (alu_result),
		.dest_reg_i         (ds_dest_i),
		.write_i            (pc_write),
		.rollback_request_o (rollback_request_o),
		.rollback_pc_o      (rollback_pc_o),
		.events             (br_evt.source)
	);

	branch_event_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.events    (br_evt.sink),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o)
	);

	assign ex_valid_o = ex_res.valid;
	assign ex_dest_o = ex_res.dest_reg;
	assign ex_write_o = ex_res.write;
	assign ex_result_o = ex_res.value;
	assign ex_pc_o = ex_res.pc;

endmodule

// File: dv/execute_unit_chk.sv
/* Protocol checks on the execute stage top level, attached to it by the bind
   at the end of this file */
`include "exec_defines.svh"

module execute_unit_chk import exec_pkg::*; (
	input logic    clk,
	input logic    reset,
	input logic    ds_valid_i,
	input alu_op_t ds_op_i,
	input logic    ex_valid_i,
	input logic    ex_write_i,
	input logic    pready_i
);
	timeunit 1ns;
	timeprecision 1ns;

	logic mul_issue;
	logic single_issue;

	assign mul_issue = ds_valid_i && ds_op_i == OP_MUL;
	assign single_issue = ds_valid_i && ds_op_i != OP_MUL;

	// A multiply reaches the merge register three issue slots later
	merge_free: assert property (@(posedge clk) disable iff (reset)
		single_issue |-> !$past(mul_issue, `EXEC_MUL_STAGES))
		else $error("one-cycle issue collides with a multiply at the merge register");

	write_needs_valid: assert property (@(posedge clk) disable iff (reset)
		ex_write_i |-> ex_valid_i)
		else $error("ex_write is high while ex_valid is low");

	no_wait_states: assert property (@(posedge clk) disable iff (reset)
		pready_i)
		else $error("APB pready dropped low");

endmodule

bind execute_unit execute_unit_chk u_chk (
	.clk        (clk),
	.reset      (reset),
	.ds_valid_i (ds_valid_i),
	.ds_op_i    (ds_op_i),
	.ex_valid_i (ex_valid_o),
	.ex_write_i (ex_write_o),
	.pready_i   (pready_o)
);

// File: dv/execute_unit_tb.sv
/* Testbench for the execute stage. Replays the per-cycle table from the test
   data file, then reads and clears the branch counters over APB */

module tb_clock (
	output logic clk_o
);
	timeunit 1ns;
	timeprecision 1ns;

	initial
	begin
		clk_o = 1'b0;
		forever
			#50 clk_o = ~clk_o;
	end
endmodule

module execute_unit_tb import exec_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ns;

	localparam string DATA_FILE = "dv/execute_unit_testdata.txt";

	logic         clk;
	logic         reset;
	logic         ds_valid;
	alu_op_t      ds_op;
	reg_idx_t     ds_src1;
	reg_idx_t     ds_src2;
	logic         ds_op2_imm;
	data_t        ds_immediate;
	reg_idx_t     ds_dest;
	logic         ds_write;
	data_t        ds_pc;
	branch_type_t ds_branch_type;
	logic         ds_predicted;
	data_t        ds_offset;
	data_t        rf_value1;
	data_t        rf_value2;
	reg_idx_t     ma_reg;
	logic         ma_write;
	data_t        ma_value;
	reg_idx_t     wb_reg;
	logic         wb_write;
	data_t        wb_value;
	logic         ex_valid;
	reg_idx_t     ex_dest;
	logic         ex_write;
	data_t        ex_result;
	data_t        ex_pc;
	logic         rollback_request;
	data_t        rollback_pc;
	data_t        paddr;
	data_t        pwdata;
	logic         psel;
	logic         penable;
	logic         pwrite;
	data_t        prdata;
	logic         pready;

	// Fields of one cycle row
	data_t s_valid, s_op, s_src1, s_src2, s_imm_sel, s_imm, s_dest, s_write, s_pc;
	data_t s_btype, s_pred, s_offset;
	data_t s_rf1, s_rf2, s_ma_reg, s_ma_write, s_ma_value, s_wb_reg, s_wb_write, s_wb_value;
	data_t e_rb, e_rb_pc, e_valid, e_dest, e_write, e_result, e_pc;

	int cycle_count = 0;
	int cycle_limit = 0;

	tb_clock u_clock (.clk_o(clk));

	execute_unit uut (
		.clk                (clk),
		.reset              (reset),
		.ds_valid_i         (ds_valid),
		.ds_op_i            (ds_op),
		.ds_src1_i          (ds_src1),
		.ds_src2_i          (ds_src2),
		.ds_op2_imm_i       (ds_op2_imm),
		.ds_immediate_i     (ds_immediate),
		.ds_dest_i          (ds_dest),
		.ds_write_i         (ds_write),
		.ds_pc_i            (ds_pc),
		.ds_branch_type_i   (ds_branch_type),
		.ds_predicted_i     (ds_predicted),
		.ds_offset_i        (ds_offset),
		.rf_value1_i        (rf_value1),
		.rf_value2_i        (rf_value2),
		.ma_reg_i           (ma_reg),
		.ma_write_i         (ma_write),
		.ma_value_i         (ma_value),
		.wb_reg_i           (wb_reg),
		.wb_write_i         (wb_write),
		.wb_value_i         (wb_value),
		.ex_valid_o         (ex_valid),
		.ex_dest_o          (ex_dest),
		.ex_write_o         (ex_write),
		.ex_result_o        (ex_result),
		.ex_pc_o            (ex_pc),
		.rollback_request_o (rollback_request),
		.rollback_pc_o      (rollback_pc),
		.paddr_i            (paddr),
		.pwdata_i           (pwdata),
		.psel_i             (psel),
		.penable_i          (penable),
		.pwrite_i           (pwrite),
		.prdata_o           (prdata),
		.pready_o           (pready)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input data_t got, input data_t exp);
		assert (got === exp)
		else
		begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic init_inputs();
		reset = 1'b1;
		ds_valid = 1'b0;
		ds_op = OP_ADD;
		ds_src1 = '0;
		ds_src2 = '0;
		ds_op2_imm = 1'b0;
		ds_immediate = '0;
		ds_dest = '0;
		ds_write = 1'b0;
		ds_pc = '0;
		ds_branch_type = BR_NONE;
		ds_predicted = 1'b0;
		ds_offset = '0;
		rf_value1 = '0;
		rf_value2 = '0;
		ma_reg = '0;
		ma_write = 1'b0;
		ma_value = '0;
		wb_reg = '0;
		wb_write = 1'b0;
		wb_value = '0;
		paddr = '0;
		pwdata = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// Line count of the data file sets the run time limit
	task automatic count_lines(output int lines);
		int fd;
		logic [8*200-1:0] line_buf;
		lines = 0;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0)
			abort_run("cannot open the test data file");
		while ($fgets(line_buf, fd) != 0)
			lines++;
		$fclose(fd);
	endtask

	task automatic read_cycle(input int fd);
		int n;
		n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", s_valid, s_op, s_src1, s_src2,
			s_imm_sel, s_imm, s_dest, s_write, s_pc);
		n += $fscanf(fd, "%h %h %h", s_btype, s_pred, s_offset);
		n += $fscanf(fd, "%h %h %h %h %h %h %h %h", s_rf1, s_rf2, s_ma_reg, s_ma_write,
			s_ma_value, s_wb_reg, s_wb_write, s_wb_value);
		n += $fscanf(fd, "%h %h %h %h %h %h %h", e_rb, e_rb_pc, e_valid, e_dest,
			e_write, e_result, e_pc);
		if (n != 27)
			abort_run("a cycle line in the test data file has missing fields");
	endtask

	task automatic drive_cycle();
		ds_valid <= s_valid[0];
		ds_op <= alu_op_t'(s_op[3:0]);
		ds_src1 <= reg_idx_t'(s_src1);
		ds_src2 <= reg_idx_t'(s_src2);
		ds_op2_imm <= s_imm_sel[0];
		ds_immediate <= s_imm;
		ds_dest <= reg_idx_t'(s_dest);
		ds_write <= s_write[0];
		ds_pc <= s_pc;
		ds_branch_type <= branch_type_t'(s_btype[2:0]);
		ds_predicted <= s_pred[0];
		ds_offset <= s_offset;
		rf_value1 <= s_rf1;
		rf_value2 <= s_rf2;
		ma_reg <= reg_idx_t'(s_ma_reg);
		ma_write <= s_ma_write[0];
		ma_value <= s_ma_value;
		wb_reg <= reg_idx_t'(s_wb_reg);
		wb_write <= s_wb_write[0];
		wb_value <= s_wb_value;
	endtask

	// Rollback belongs to this row's issue, ex_* to an earlier one
	task automatic check_cycle();
		check_value("rollback_request", data_t'(rollback_request), e_rb);
		if (e_rb[0])
			check_value("rollback_pc", rollback_pc, e_rb_pc);
		check_value("ex_valid", data_t'(ex_valid), e_valid);
		check_value("ex_write", data_t'(ex_write), e_write);
		if (e_valid[0])
		begin
			check_value("ex_dest", data_t'(ex_dest), e_dest);
			check_value("ex_result", ex_result, e_result);
			check_value("ex_pc", ex_pc, e_pc);
		end
	endtask

	// Setup then access phase; reads are checked in the access cycle
	task automatic apb_access(input logic write, input data_t addr, input data_t wdata,
		input data_t exp);
		@(posedge clk);
		ds_valid <= 1'b0;
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		// The slave never inserts wait states
		check_value("pready", data_t'(pready), 32'd1);
		if (!write)
			check_value("prdata", prdata, exp);
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit)
			abort_run("timeout: the test data did not finish within the cycle limit");
	end

	initial
	begin
		int fd;
		int kind;
		int lines;
		data_t addr;
		data_t wdata;
		data_t exp;
		init_inputs();
		count_lines(lines);
		cycle_limit = lines + 20;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0)
			abort_run("cannot open the test data file");
		repeat (3)
			@(posedge clk);
		reset <= 1'b0;
		// Kind 0 is a cycle row, 1 an APB read, 2 an APB write
		while ($fscanf(fd, "%h", kind) == 1)
		begin
			if (kind == 0)
			begin
				read_cycle(fd);
				@(posedge clk);
				drive_cycle();
				@(negedge clk);
				check_cycle();
			end
			else
			begin
				if ($fscanf(fd, "%h %h %h", addr, wdata, exp) != 3)
					abort_run("an APB line in the test data file has missing fields");
				apb_access(kind == 2, addr, wdata, exp);
			end
		end
		$fclose(fd);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		@(posedge clk);
		$display("** PASS **");
		$finish;
	end

endmodule

// File: execute_unit.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/exec_ifs.sv
rtl/operand_bypass.sv
rtl/branch_resolve.sv
rtl/latency_pipe.sv
rtl/exec_alu.sv
rtl/branch_event_regs.sv
rtl/execute_unit.sv
dv/execute_unit_chk.sv
dv/execute_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the execute stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module execute_unit_tb -f execute_unit.f -o execute_unit_sim
./obj_dir/execute_unit_sim

// File: dv/execute_unit_testdata.txt
0  0 0 0 0 0 0 0 0 0  0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
0  1 0 1 2 1 5 3 1 100  0 0 0  10 20 0 0 0 0 0 0  0 0 0 0 0 0 0
0  1 1 1 2 0 0 4 1 104  0 0 0  30 8 0 0 0 0 0 0  0 0 1 3 1 15 100
0  1 2 1 2 0 0 5 1 108  0 0 0  ff f0 0 0 0 0 0 0  0 0 1 4 1 28 104
0  1 3 1 2 0 0 6 1 10c  0 0 0  f0 f 0 0 0 0 0 0  0 0 1 5 1 f0 108
0  1 4 1 2 0 0 7 0 110  0 0 0  ff f 0 0 0 0 0 0  0 0 1 6 1 ff 10c
0  1 5 1 2 1 4 8 1 114  0 0 0  3 0 0 0 0 0 0 0  0 0 1 7 0 f0 110
0  1 6 1 2 1 1f 9 1 118  0 0 0  80000000 0 0 0 0 0 0 0  0 0 1 8 1 30 114
0  1 7 1 2 0 0 a 1 11c  0 0 0  ffffffff 1 0 0 0 0 0 0  0 0 1 9 1 1 118
0  1 8 1 2 0 0 b 1 120  0 0 0  7 7 0 0 0 0 0 0  0 0 1 a 1 1 11c
0  1 0 b 1f 0 0 c 1 200  0 0 0  70 99 b 1 50 b 1 60  0 0 1 b 1 1 120
0  1 0 b 2 1 0 d 1 204  0 0 0  70 99 b 1 50 b 1 60  0 0 1 c 1 201 200
0  1 0 b 3 0 0 e 1 208  0 0 0  70 3 b 0 50 b 1 60  0 0 1 d 1 50 204
0  1 0 b e 0 0 f 1 20c  0 0 0  70 99 e 1 11 b 0 60  0 0 1 e 1 63 208
0  1 9 1 2 0 0 10 1 300  0 0 0  6 7 0 0 0 0 0 0  0 0 1 f 1 d3 20c
0  1 9 1 2 0 0 11 0 304  0 0 0  3 5 0 0 0 0 0 0  0 0 0 0 0 0 0
0  0 0 0 0 0 0 0 0 0  0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
0  0 0 0 0 0 0 0 0 0  0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
0  0 0 0 0 0 0 0 0 0  0 0 0  0 0 0 0 0 0 0 0  0 0 1 10 1 2a 300
0  1 0 1 2 0 0 0 0 400  1 0 20  0 0 0 0 0 0 0 0  1 420 1 11 0 f 304
0  1 0 1 2 0 0 0 0 404  2 1 8  5 0 0 0 0 0 0 0  0 0 1 0 0 0 400
0  1 0 1 2 0 0 0 0 408  2 1 8  0 0 0 0 0 0 0 0  1 408 1 0 0 5 404
0  1 0 1 2 0 0 0 0 40c  3 0 fffffff4  0 0 0 0 0 0 0 0  1 400 1 0 0 0 408
0  1 0 1 2 0 0 1e 1 410  4 1 40  0 0 0 0 0 0 0 0  0 0 1 0 0 0 40c
0  1 0 1 2 0 0 1e 1 414  4 0 100  0 0 0 0 0 0 0 0  1 514 1 1e 1 410 410
0  1 0 1 2 1 4 1f 1 418  0 0 0  500 0 0 0 0 0 0 0  1 504 1 1e 1 414 414
0  1 0 1 2 0 0 0 0 41c  1 0 8  3 0 0 0 0 0 0 0  0 0 1 1f 1 504 418
0  0 0 0 0 0 0 0 0 0  0 0 0  0 0 0 0 0 0 0 0  0 0 1 0 0 3 41c
0  0 0 0 0 0 0 0 0 0  0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
1  0 0 5
1  4 0 2
1  8 0 2
1  c 0 4
2  4 ffffffff 0
1  4 0 0
1  0 0 5
